/* source/hdc_params_pkg.sv */
`default_nettype none

package hdc_params_pkg;

    // hypervector geometry
    localparam int HV_WIDTH     = 256;
    localparam int WORD_WIDTH   = 32;
    localparam int WORDS_PER_HV = HV_WIDTH / WORD_WIDTH;

    // item memory geometry
    localparam int ITEM_DEPTH  = 64;
    localparam int ITEM_ADDR_W = $clog2(ITEM_DEPTH);

    // derived index widths
    localparam int WORD_IDX_W = $clog2(WORDS_PER_HV);
    localparam int ROT_W      = $clog2(HV_WIDTH);

    // nonzero xorshift start value
    localparam logic [WORD_WIDTH-1:0] PRNG_SEED = 32'd2463534242;

    // one full hypervector
    typedef logic [HV_WIDTH-1:0] hv_t;

    // one generator output word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // item memory address
    typedef logic [ITEM_ADDR_W-1:0] item_addr_t;

    // number of items from 1 up to ITEM_DEPTH
    typedef logic [ITEM_ADDR_W:0] item_count_t;

    // word slot inside a hypervector
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // left rotation amount
    typedef logic [ROT_W-1:0] rot_t;

endpackage

`default_nettype wire

/* source/hdc_isa_pkg.sv */
`default_nettype none

package hdc_isa_pkg;

    localparam int INSTR_WIDTH = 16;

    // field positions inside an instruction word
    localparam int OPC_MSB     = 15;
    localparam int OPC_LSB     = 12;
    localparam int OPERAND_MSB = 7;
    localparam int OPERAND_LSB = 0;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // decoder never looks at reserved bits 11..8
    // unlisted codes fall through to nop behaviour
    typedef enum logic [OPC_MSB-OPC_LSB:0] {
        OP_NOP     = 4'd0,
        OP_LOAD    = 4'd1,
        OP_BIND    = 4'd2,
        OP_PERMUTE = 4'd3,
        OP_STORE   = 4'd4,
        OP_LAST    = 4'd5
    } opcode_e;

endpackage

`default_nettype wire

/* source/xorshift_prng.sv */
`timescale 1ns/1ps
`default_nettype none

module xorshift_prng import hdc_params_pkg::*; (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   reseed,
    input  wire   step,
    output word_t word
);

    word_t state;
    word_t t0;
    word_t t1;
    word_t next_state;

    // 13 / 17 / 5 shift triple
    always_comb begin
        t0         = state ^ (state << 13);
        t1         = t0 ^ (t0 >> 17);
        next_state = t1 ^ (t1 << 5);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PRNG_SEED;
        end else if (reseed) begin
            state <= PRNG_SEED;
        end else if (step) begin
            state <= next_state;
        end
    end

    assign word = state;

endmodule

`default_nettype wire

/* source/item_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module item_generator import hdc_params_pkg::*; (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              gen_start,
    input  wire item_count_t item_count,
    output logic             gen_busy,
    output logic             gen_done,
    output logic             wr_en,
    output item_addr_t       wr_addr,
    output hv_t              wr_data
);

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        FINISH
    } gen_state_e;

    gen_state_e state;
    word_t      word;
    logic       start;
    logic       step;
    logic       primed;
    logic       capture;
    logic       last_word;
    word_idx_t  word_idx;
    item_addr_t item_addr;
    item_addr_t last_addr;
    hv_t        vec;

    assign start     = gen_start && (state != FILL);
    assign step      = (state == FILL);
    // first word after reseed is the bare seed and gets skipped
    assign capture   = (state == FILL) && primed;
    assign last_word = (word_idx == word_idx_t'(WORDS_PER_HV - 1));

    xorshift_prng prng0 (
        .clk    (clk),
        .arst_n (arst_n),
        .reseed (start),
        .step   (step),
        .word   (word)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            primed    <= 1'b0;
            word_idx  <= '0;
            item_addr <= '0;
            last_addr <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
        end else begin
            // write one cycle after the eighth word lands
            wr_en <= capture && last_word;
            if (start) begin
                state     <= FILL;
                primed    <= 1'b0;
                word_idx  <= '0;
                item_addr <= '0;
                last_addr <= item_addr_t'(item_count - 1'b1);
            end else if (state == FINISH) begin
                state <= IDLE;
            end else if (state == FILL) begin
                primed <= 1'b1;
                if (capture) begin
                    word_idx <= word_idx + 1'b1;
                    if (last_word) begin
                        wr_addr   <= item_addr;
                        item_addr <= item_addr + 1'b1;
                        if (item_addr == last_addr) begin
                            state <= FINISH;
                        end
                    end
                end
            end
        end
    end

    // word 0 lands in the low slot
    always_ff @(posedge clk) begin
        if (capture) begin
            vec[word_idx*WORD_WIDTH +: WORD_WIDTH] <= word;
        end
    end

    assign wr_data  = vec;
    assign gen_busy = (state == FILL);
    assign gen_done = (state == FINISH);

endmodule

`default_nettype wire

/* source/item_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module item_memory import hdc_params_pkg::*; (
    input  wire             clk,
    input  wire             wr_en,
    input  wire item_addr_t wr_addr,
    input  wire hv_t        wr_data,
    input  wire item_addr_t rd_addr,
    output hv_t             rd_data
);

    hv_t mem [ITEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port runs every cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/hdc_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_execute import hdc_params_pkg::*, hdc_isa_pkg::*; (
    input  wire             clk,
    input  wire             arst_n,
    input  wire instr_t     instr,
    input  wire             instr_valid,
    output logic            instr_ready,
    output item_addr_t      rd_addr,
    input  wire hv_t        rd_data,
    output hv_t             result,
    output logic            result_last,
    output logic            result_valid,
    input  wire             result_ready
);

    logic                  s1_vld;
    logic                  s2_vld;
    instr_t                s1_instr;
    instr_t                s2_instr;
    opcode_e               s2_op;
    rot_t                  s2_amt;
    hv_t                   acc;
    hv_t                   acc_rot;
    logic [2*HV_WIDTH-1:0] rot_dbl;
    logic                  s2_emits;
    logic                  stall;
    logic                  exec;

    // stage 1 addresses the item memory and data returns in stage 2
    assign rd_addr = item_addr_t'(s1_instr[OPERAND_MSB:OPERAND_LSB]);

    assign s2_op  = opcode_e'(s2_instr[OPC_MSB:OPC_LSB]);
    assign s2_amt = rot_t'(s2_instr[OPERAND_MSB:OPERAND_LSB]);

    assign s2_emits = s2_vld && ((s2_op == OP_STORE) || (s2_op == OP_LAST));

    // output still occupied and not drained this cycle
    assign stall       = s2_emits && result_valid && !result_ready;
    assign exec        = s2_vld && !stall;
    assign instr_ready = !stall;

    // rotate left through the upper half of the doubled vector
    always_comb begin
        rot_dbl = {acc, acc} << s2_amt;
        acc_rot = rot_dbl[2*HV_WIDTH-1 -: HV_WIDTH];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (!stall) begin
            s1_vld <= instr_valid;
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_instr <= instr;
            s2_instr <= s1_instr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (exec) begin
            case (s2_op)
                OP_LOAD:    acc <= rd_data;
                OP_BIND:    acc <= acc ^ rd_data;
                OP_PERMUTE: acc <= acc_rot;
                default:    acc <= acc;
            endcase
        end
    end

    // new beat only when the slot is free or drains now
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result_last  <= 1'b0;
        end else if (exec && s2_emits) begin
            result_valid <= 1'b1;
            result_last  <= (s2_op == OP_LAST);
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    // end marker carries an all-zero vector
    always_ff @(posedge clk) begin
        if (exec && s2_emits) begin
            result <= (s2_op == OP_LAST) ? '0 : acc;
        end
    end

endmodule

`default_nettype wire

/* source/hdc_core.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_core import hdc_params_pkg::*, hdc_isa_pkg::*; (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              gen_start,
    input  wire item_count_t item_count,
    output logic             gen_busy,
    output logic             gen_done,
    input  wire instr_t      instr,
    input  wire              instr_valid,
    output logic             instr_ready,
    output hv_t              result,
    output logic             result_last,
    output logic             result_valid,
    input  wire              result_ready
);

    logic       wr_en;
    item_addr_t wr_addr;
    hv_t        wr_data;
    item_addr_t rd_addr;
    hv_t        rd_data;
    logic       exe_valid;
    logic       exe_ready;

    item_generator gen0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .gen_start  (gen_start),
        .item_count (item_count),
        .gen_busy   (gen_busy),
        .gen_done   (gen_done),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    item_memory mem0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // no intake while the item memory is being filled
    assign exe_valid   = instr_valid && !gen_busy;
    assign instr_ready = exe_ready && !gen_busy;

    hdc_execute exe0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (exe_valid),
        .instr_ready  (exe_ready),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .result       (result),
        .result_last  (result_last),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

/* verification/hdc_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_core_sva import hdc_params_pkg::*; (
    input wire      clk,
    input wire      arst_n,
    input wire      gen_busy,
    input wire      gen_done,
    input wire      instr_ready,
    input wire hv_t result,
    input wire      result_last,
    input wire      result_valid,
    input wire      result_ready
);

    int failures = 0;

    // a stalled beat keeps its payload until taken
    property beat_held;
        @(posedge clk) disable iff (!arst_n)
            result_valid && !result_ready |=>
                result_valid && $stable(result) && $stable(result_last);
    endproperty

    property no_intake_while_busy;
        @(posedge clk) disable iff (!arst_n)
            gen_busy |-> !instr_ready;
    endproperty

    property done_is_pulse;
        @(posedge clk) disable iff (!arst_n)
            gen_done |=> !gen_done;
    endproperty

    beat_held_a: assert property (beat_held)
        else begin
            $error("result beat changed while the output was stalled");
            failures++;
        end

    no_intake_a: assert property (no_intake_while_busy)
        else begin
            $error("instr_ready high during item generation");
            failures++;
        end

    done_pulse_a: assert property (done_is_pulse)
        else begin
            $error("gen_done held for more than one cycle");
            failures++;
        end

endmodule

`default_nettype wire

/* verification/hdc_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_core_tb import hdc_params_pkg::*, hdc_isa_pkg::*; ();

    localparam int TBL_MAX       = 128;
    localparam int GEN_COUNT     = 16;
    localparam int REGEN_COUNT   = 4;
    localparam int CYC_PER_ENTRY = 20;

    logic        clk;
    logic        arst_n;
    logic        gen_start;
    item_count_t item_count;
    logic        gen_busy;
    logic        gen_done;
    instr_t      instr;
    logic        instr_valid;
    logic        instr_ready;
    hv_t         result;
    logic        result_last;
    logic        result_valid;
    logic        result_ready;

    // stimulus table with one row per instruction
    string  tbl_name [TBL_MAX];
    instr_t tbl_instr [TBL_MAX];
    logic   tbl_emit [TBL_MAX];
    logic   tbl_last [TBL_MAX];
    hv_t    tbl_data [TBL_MAX];
    logic   tbl_slow [TBL_MAX];
    logic   tbl_regen [TBL_MAX];
    int     n_entries;

    hv_t  items [GEN_COUNT];
    int   pending [$];
    logic build_slow;
    logic throttle;
    logic table_built;
    int   n_tests;
    int   n_fail;
    int   n_beats;

    hdc_core dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .gen_start    (gen_start),
        .item_count   (item_count),
        .gen_busy     (gen_busy),
        .gen_done     (gen_done),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_last  (result_last),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    bind hdc_core hdc_core_sva sva0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .gen_busy     (gen_busy),
        .gen_done     (gen_done),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_last  (result_last),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    always #2 clk = ~clk;

    function automatic word_t xorshift_next(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // bit i lands on bit (i + amt) mod width
    function automatic hv_t rotate_left(input hv_t v, input int amt);
        hv_t r;
        int  i;
        for (i = 0; i < HV_WIDTH; i++) begin
            r[(i + amt) % HV_WIDTH] = v[i];
        end
        return r;
    endfunction

    function automatic instr_t encode(input logic [3:0] op, input logic [3:0] rsv,
                                      input logic [7:0] operand);
        return {op, rsv, operand};
    endfunction

    // expected item memory with the first word in the low slot
    task automatic build_items();
        word_t s;
        s = PRNG_SEED;
        for (int k = 0; k < GEN_COUNT; k++) begin
            for (int j = 0; j < WORDS_PER_HV; j++) begin
                s = xorshift_next(s);
                items[k][j*WORD_WIDTH +: WORD_WIDTH] = s;
            end
        end
    endtask

    task automatic add_entry(input string name, input instr_t ins, input logic emit,
                             input hv_t data);
        tbl_name[n_entries]  = name;
        tbl_instr[n_entries] = ins;
        tbl_emit[n_entries]  = emit;
        tbl_last[n_entries]  = emit && (ins[15:12] == OP_LAST);
        tbl_data[n_entries]  = data;
        tbl_slow[n_entries]  = build_slow;
        tbl_regen[n_entries] = 1'b0;
        n_entries++;
    endtask

    task automatic build_table();
        hv_t e;
        int  amts [4];
        amts = '{0, 1, 37, 255};
        n_entries  = 0;
        build_slow = 1'b0;
        for (int k = 0; k < GEN_COUNT; k++) begin
            add_entry("", encode(OP_LOAD, 4'h0, 8'(k)), 1'b0, '0);
            add_entry($sformatf("load_store_%0d", k), encode(OP_STORE, 4'h0, 8'h00), 1'b1,
                      items[k]);
        end
        // bind twice with one item cancels out
        e = items[3] ^ items[7];
        add_entry("", encode(OP_LOAD, 4'h0, 8'd3), 1'b0, '0);
        add_entry("", encode(OP_BIND, 4'h0, 8'd7), 1'b0, '0);
        add_entry("bind_3_7", encode(OP_STORE, 4'h0, 8'h00), 1'b1, e);
        add_entry("", encode(OP_BIND, 4'h0, 8'd9), 1'b0, '0);
        add_entry("", encode(OP_BIND, 4'h0, 8'd9), 1'b0, '0);
        add_entry("bind_twice", encode(OP_STORE, 4'h0, 8'h00), 1'b1, e);
        e = items[5];
        add_entry("", encode(OP_LOAD, 4'h0, 8'd5), 1'b0, '0);
        for (int a = 0; a < 4; a++) begin
            e = rotate_left(e, amts[a]);
            add_entry("", encode(OP_PERMUTE, 4'h0, 8'(amts[a])), 1'b0, '0);
            add_entry($sformatf("permute_%0d", amts[a]), encode(OP_STORE, 4'h0, 8'h00), 1'b1,
                      e);
        end
        add_entry("last_marker", encode(OP_LAST, 4'h0, 8'h00), 1'b1, '0);
        add_entry("", encode(OP_LOAD, 4'h0, 8'd11), 1'b0, '0);
        add_entry("", encode(OP_NOP, 4'hA, 8'h33), 1'b0, '0);
        add_entry("", encode(4'h9, 4'h0, 8'd2), 1'b0, '0);
        add_entry("", encode(4'hF, 4'h5, 8'hFF), 1'b0, '0);
        add_entry("nop_undefined", encode(OP_STORE, 4'h0, 8'h00), 1'b1, items[11]);
        // this load is offered while the memory is regenerated
        add_entry("", encode(OP_LOAD, 4'h0, 8'd2), 1'b0, '0);
        tbl_regen[n_entries-1] = 1'b1;
        add_entry("after_regen", encode(OP_STORE, 4'h0, 8'h00), 1'b1, items[2]);
        build_slow = 1'b1;
        for (int k = 0; k < 8; k++) begin
            e = items[k] ^ items[k+8];
            add_entry("", encode(OP_LOAD, 4'h0, 8'(k)), 1'b0, '0);
            add_entry("", encode(OP_BIND, 4'h0, 8'(k + 8)), 1'b0, '0);
            add_entry($sformatf("slow_%0d", k), encode(OP_STORE, 4'h0, 8'h00), 1'b1, e);
            add_entry($sformatf("slow_%0d_again", k), encode(OP_STORE, 4'h0, 8'h00), 1'b1, e);
        end
        add_entry("slow_last", encode(OP_LAST, 4'h0, 8'h00), 1'b1, '0);
    endtask

    task automatic run_generation(input int count, input string name);
        int cycles;
        @(negedge clk);
        gen_start  = 1'b1;
        item_count = item_count_t'(count);
        @(negedge clk);
        gen_start = 1'b0;
        #1;
        cycles = 1;
        while (!gen_done && cycles < count * WORDS_PER_HV + 8) begin
            assert (gen_busy && !instr_ready) else begin
                $display("%s: gen_busy low or instr_ready high while generating", name);
                n_fail++;
            end
            @(negedge clk);
            #1;
            cycles++;
        end
        n_tests++;
        assert (gen_done && !gen_busy && cycles == count * WORDS_PER_HV + 2)
            $display("ok   %s", name);
        else begin
            $display("FAIL %s expected %0d cycles to gen_done actual %0d (done=%b)", name,
                     count * WORDS_PER_HV + 2, cycles, gen_done);
            n_fail++;
        end
    endtask

    task automatic issue(input int idx);
        logic saw_done;
        throttle = tbl_slow[idx];
        if (tbl_regen[idx]) begin
            @(negedge clk);
            instr_valid = 1'b0;
            gen_start   = 1'b1;
            item_count  = item_count_t'(REGEN_COUNT);
        end
        @(negedge clk);
        gen_start   = 1'b0;
        instr       = tbl_instr[idx];
        instr_valid = 1'b1;
        #1;
        saw_done = gen_done;
        while (!instr_ready) begin
            @(negedge clk);
            #1;
            saw_done = saw_done || gen_done;
        end
        if (tbl_regen[idx]) begin
            n_tests++;
            assert (saw_done) $display("ok   regen_intake");
            else begin
                $display("instruction was taken before gen_done of the regeneration");
                n_fail++;
            end
        end
        if (tbl_emit[idx]) begin
            pending.push_back(idx);
        end
    endtask

    task automatic check_beat();
        int idx;
        n_beats++;
        assert (pending.size() > 0) else begin
            $display("result beat arrived with no instruction waiting for it");
            n_fail++;
        end
        if (pending.size() > 0) begin
            idx = pending.pop_front();
            n_tests++;
            assert (result === tbl_data[idx] && result_last === tbl_last[idx])
                $display("ok   %s", tbl_name[idx]);
            else begin
                $display("FAIL %s expected %h last %b actual %h last %b", tbl_name[idx],
                         tbl_data[idx], tbl_last[idx], result, result_last);
                n_fail++;
            end
        end
    endtask

    // ready picked on the falling edge and beat taken at the next rising edge
    always begin
        @(negedge clk);
        result_ready = throttle ? (($urandom % 3) != 0) : 1'b1;
        #1;
        if (result_valid && result_ready) begin
            check_beat();
        end
    end

    initial begin
        wait (table_built);
        repeat (n_entries * CYC_PER_ENTRY + (GEN_COUNT + REGEN_COUNT) * WORDS_PER_HV + 12)
            @(posedge clk);
        $display("watchdog expired before all results came back");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        gen_start    = 1'b0;
        item_count   = '0;
        instr        = '0;
        instr_valid  = 1'b0;
        result_ready = 1'b0;
        throttle     = 1'b0;
        table_built  = 1'b0;
        n_tests      = 0;
        n_fail       = 0;
        n_beats      = 0;
        void'($urandom(32'h7d26979b));
        build_items();
        build_table();
        table_built = 1'b1;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        #1;
        n_tests++;
        assert (!result_valid && !result_last && !gen_busy && !gen_done && instr_ready)
            $display("ok   reset_state");
        else begin
            $display("outputs do not hold their reset values after reset");
            n_fail++;
        end
        run_generation(GEN_COUNT, "gen_16_items");
        for (int i = 0; i < n_entries; i++) begin
            issue(i);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        throttle    = 1'b0;
        while (pending.size() > 0) begin
            @(negedge clk);
        end
        // catch stray beats
        repeat (10) @(negedge clk);
        n_fail = n_fail + dut0.sva0.failures;
        $display("tests %0d, beats %0d, failures %0d", n_tests, n_beats, n_fail);
        if (n_fail == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/hdc_params_pkg.sv
source/hdc_isa_pkg.sv
source/xorshift_prng.sv
source/item_generator.sv
source/item_memory.sv
source/hdc_execute.sv
source/hdc_core.sv
verification/hdc_core_sva.sv
verification/hdc_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = hdc_core_tb
FILELIST = list.f
SIM_ARGS = +verilator+error+limit+100
PASS_MSG = ** PASS **

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
